/* design/isa_pkg.sv */
////////////////////
// instruction set definitions
// widths, instruction word layout, classes and opcodes
////////////////////
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;    // data and register width
    localparam int NUM_REGS   = 32;
    localparam int REG_AW     = 5;
    localparam int PC_W       = 8;     // word index into both memories
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int IMM_W      = 12;

    typedef enum logic [1:0] {
        MOVEMENT   = 2'b00,
        FLOWCTRL   = 2'b01,
        LOGIC      = 2'b10,
        ARITHMETIC = 2'b11
    } instr_class_e;

    typedef enum logic [2:0] {
        OP_LOAD  = 3'b000,
        OP_LOADI = 3'b001,
        OP_STORE = 3'b010,
        OP_MOV   = 3'b100
    } mov_op_e;

    typedef enum logic [2:0] {
        OP_OR  = 3'b000,
        OP_INV = 3'b001,
        OP_AND = 3'b010
    } logic_op_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'b000,
        OP_SUB = 3'b001
    } arith_op_e;

    typedef enum logic [2:0] {
        OP_JUMP = 3'b000,
        OP_BZ   = 3'b001,
        OP_BNZ  = 3'b010,
        OP_JAL  = 3'b101,
        OP_RET  = 3'b111
    } flow_op_e;

    // instruction word, msb first: class 31:30, opc 29:27, imm 26:15, rc, rb, ra
    typedef struct packed {
        instr_class_e      cls;
        logic [2:0]        opc;
        logic [IMM_W-1:0]  imm;
        logic [REG_AW-1:0] rc;
        logic [REG_AW-1:0] rb;
        logic [REG_AW-1:0] ra;
    } instr_t;

endpackage

`default_nettype wire

/* design/core_pkg.sv */
////////////////////
// datapath control types
// alu ops, operand and write-back selects, next pc
////////////////////
`default_nettype none

package core_pkg;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_OR, ALU_AND, ALU_INV, ALU_PASS_B, ALU_ZERO
    } alu_op_e;

    // second alu operand, the first is always rb
    typedef enum logic [1:0] {
        SRC_RC, SRC_IMM, SRC_IMM_RC, SRC_PC
    } alu_src_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_LINK
    } wb_src_e;

    typedef enum logic [2:0] {
        SEQ, BRANCH_ZERO, BRANCH_NONZERO, TARGET_ALU, TARGET_RB
    } next_pc_e;

    typedef struct packed {
        alu_op_e                   alu_op;
        alu_src_e                  alu_src;
        wb_src_e                   wb_src;
        next_pc_e                  next_pc;
        logic                      rf_wen;
        logic                      mem_wen;
        logic [isa_pkg::XLEN-1:0]  imm_ext;     // imm sign extended
        logic [isa_pkg::XLEN-1:0]  imm_rc_ext;  // {imm, rc} sign extended
    } ctrl_t;

endpackage

`default_nettype wire

/* design/cpu_ifs.sv */
////////////////////
// regfile_if: two read ports, one write port
// dmem_if: data memory access
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;
    import isa_pkg::*;

    logic [REG_AW-1:0] rb_addr;
    logic [REG_AW-1:0] rc_addr;
    logic [XLEN-1:0]   rb_data;
    logic [XLEN-1:0]   rc_data;
    logic              wen;      // one cycle write strobe
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   wdata;

    // decoder drives the read side, execute unit the write side
    modport core (output rb_addr, rc_addr, wen, waddr, wdata,
                  input  rb_data, rc_data);
    modport regs (input  rb_addr, rc_addr, wen, waddr, wdata,
                  output rb_data, rc_data);
endinterface

interface dmem_if;
    import isa_pkg::*;

    logic            wen;
    logic [PC_W-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;   // async from addr

    modport core (output wen, addr, wdata, input rdata);
    modport mem  (input  wen, addr, wdata, output rdata);
endinterface

`default_nettype wire

/* design/fetch_unit.sv */
////////////////////
// fetch unit
// pc, run flag, loadable instruction memory
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                       i_clk,
    input  wire logic                       i_reset,
    input  wire logic                       i_imem_we,
    input  wire logic [isa_pkg::PC_W-1:0]   i_imem_addr,
    input  wire logic [isa_pkg::XLEN-1:0]   i_imem_wdata,
    input  wire logic                       i_redirect,
    input  wire logic [isa_pkg::PC_W-1:0]   i_target,
    output logic      [isa_pkg::PC_W-1:0]   o_pc,
    output logic      [isa_pkg::XLEN-1:0]   o_instr,
    output logic                            o_running
);
    import isa_pkg::*;

    logic [XLEN-1:0] imem [IMEM_DEPTH];

    // program load port, open during reset as well
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_wdata;
        end
    end

    assign o_instr = imem[o_pc];   // async read

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc      <= '0;
            o_running <= 1'b0;
        end else begin
            o_running <= 1'b1;     // first edge out of reset only arms the core
            if (o_running) begin
                o_pc <= i_redirect ? i_target : o_pc + PC_W'(1);   // wraps at 8 bits
            end
        end
    end

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
////////////////////
// instruction decoder
// field split, immediates, control word
////////////////////
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire logic [isa_pkg::XLEN-1:0]   i_instr,
    input  wire logic                       i_running,
    regfile_if.core                         rf,
    output core_pkg::ctrl_t                 o_ctrl,
    output logic      [isa_pkg::REG_AW-1:0] o_ra_addr
);
    import isa_pkg::*;
    import core_pkg::*;

    instr_t          instr;
    logic            is_mov;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] imm_rc_ext;

    assign instr     = instr_t'(i_instr);
    assign o_ra_addr = instr.ra;
    assign is_mov    = (instr.cls == MOVEMENT) && (instr.opc == OP_MOV);

    assign rf.rb_addr = instr.rb;
    assign rf.rc_addr = is_mov ? instr.rb : instr.rc;   // mov moves rb over the rc port

    assign imm_ext    = {{(XLEN-IMM_W){instr.imm[IMM_W-1]}}, instr.imm};
    assign imm_rc_ext = {{(XLEN-IMM_W-REG_AW){instr.imm[IMM_W-1]}}, instr.imm, instr.rc};

    always_comb begin
        // no-op unless a known class/opcode pair matches
        o_ctrl.alu_op     = ALU_ZERO;
        o_ctrl.alu_src    = SRC_RC;
        o_ctrl.wb_src     = WB_ALU;
        o_ctrl.next_pc    = SEQ;
        o_ctrl.rf_wen     = 1'b0;
        o_ctrl.mem_wen    = 1'b0;
        o_ctrl.imm_ext    = imm_ext;
        o_ctrl.imm_rc_ext = imm_rc_ext;

        case (instr.cls)
            MOVEMENT: begin
                case (mov_op_e'(instr.opc))
                    OP_LOAD: begin
                        o_ctrl.alu_op  = ALU_ADD;
                        o_ctrl.alu_src = SRC_IMM_RC;
                        o_ctrl.wb_src  = WB_MEM;
                        o_ctrl.rf_wen  = 1'b1;
                    end
                    OP_STORE: begin
                        o_ctrl.alu_op  = ALU_ADD;
                        o_ctrl.alu_src = SRC_IMM;
                        o_ctrl.mem_wen = 1'b1;
                    end
                    OP_LOADI: begin
                        o_ctrl.alu_op  = ALU_PASS_B;
                        o_ctrl.alu_src = SRC_IMM_RC;
                        o_ctrl.rf_wen  = 1'b1;
                    end
                    OP_MOV: begin
                        o_ctrl.alu_op  = ALU_PASS_B;
                        o_ctrl.rf_wen  = 1'b1;
                    end
                    default: ;
                endcase
            end
            LOGIC: begin
                o_ctrl.rf_wen = 1'b1;
                case (logic_op_e'(instr.opc))
                    OP_OR:   o_ctrl.alu_op = ALU_OR;
                    OP_AND:  o_ctrl.alu_op = ALU_AND;
                    OP_INV:  o_ctrl.alu_op = ALU_INV;
                    default: o_ctrl.rf_wen = 1'b0;
                endcase
            end
            ARITHMETIC: begin
                o_ctrl.rf_wen = 1'b1;
                case (arith_op_e'(instr.opc))
                    OP_ADD:  o_ctrl.alu_op = ALU_ADD;
                    OP_SUB:  o_ctrl.alu_op = ALU_SUB;
                    default: o_ctrl.rf_wen = 1'b0;
                endcase
            end
            FLOWCTRL: begin
                case (flow_op_e'(instr.opc))
                    OP_JUMP: begin
                        o_ctrl.alu_op  = ALU_ADD;      // rb + pc
                        o_ctrl.alu_src = SRC_PC;
                        o_ctrl.next_pc = TARGET_ALU;
                    end
                    OP_BZ, OP_BNZ: begin
                        o_ctrl.alu_op  = ALU_ADD;      // rb + imm, pc added in execute
                        o_ctrl.alu_src = SRC_IMM;
                        o_ctrl.next_pc = (instr.opc == OP_BZ) ? BRANCH_ZERO : BRANCH_NONZERO;
                    end
                    OP_JAL: begin
                        o_ctrl.alu_op  = ALU_PASS_B;
                        o_ctrl.alu_src = SRC_IMM_RC;
                        o_ctrl.wb_src  = WB_LINK;
                        o_ctrl.next_pc = TARGET_ALU;
                        o_ctrl.rf_wen  = 1'b1;
                    end
                    OP_RET:  o_ctrl.next_pc = TARGET_RB;
                    default: ;
                endcase
            end
            default: ;
        endcase

        // nothing retires before the run flag is up
        o_ctrl.rf_wen  = o_ctrl.rf_wen & i_running;
        o_ctrl.mem_wen = o_ctrl.mem_wen & i_running;
    end

endmodule

`default_nettype wire

/* design/register_file.sv */
////////////////////
// register file, 32 x 32
// two async reads, one sync write
////////////////////
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic i_clk,
    input  wire logic i_reset,
    regfile_if.regs   rf
);
    import isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wen) begin
            regs[rf.waddr] <= rf.wdata;   // every register is writable, no hardwired zero
        end
    end

    assign rf.rb_data = regs[rf.rb_addr];
    assign rf.rc_data = regs[rf.rc_addr];

endmodule

`default_nettype wire

/* design/execute_unit.sv */
////////////////////
// execute unit
// alu, branch resolution, write-back select
////////////////////
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire core_pkg::ctrl_t            i_ctrl,
    input  wire logic [isa_pkg::REG_AW-1:0] i_ra_addr,
    input  wire logic [isa_pkg::PC_W-1:0]   i_pc,
    regfile_if.core                         rf,
    dmem_if.core                            dm,
    output logic                            o_redirect,
    output logic      [isa_pkg::PC_W-1:0]   o_target
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [XLEN-1:0] opnd_b;
    logic [XLEN-1:0] alu_res;
    logic [PC_W-1:0] pc_inc;
    logic [PC_W-1:0] pc_rel;
    logic            rc_zero;

    ////////////////////
    // alu
    always_comb begin
        case (i_ctrl.alu_src)
            SRC_RC:     opnd_b = rf.rc_data;
            SRC_IMM:    opnd_b = i_ctrl.imm_ext;
            SRC_IMM_RC: opnd_b = i_ctrl.imm_rc_ext;
            default:    opnd_b = {{(XLEN-PC_W){1'b0}}, i_pc};
        endcase
    end

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:    alu_res = rf.rb_data + opnd_b;
            ALU_SUB:    alu_res = rf.rb_data - opnd_b;
            ALU_OR:     alu_res = rf.rb_data | opnd_b;
            ALU_AND:    alu_res = rf.rb_data & opnd_b;
            ALU_INV:    alu_res = ~rf.rb_data;
            ALU_PASS_B: alu_res = opnd_b;
            default:    alu_res = '0;
        endcase
    end

    ////////////////////
    // next pc
    assign pc_inc  = i_pc + PC_W'(1);
    assign pc_rel  = i_pc + alu_res[PC_W-1:0];   // branches and jal
    assign rc_zero = (rf.rc_data == '0);

    always_comb begin
        o_redirect = 1'b0;
        o_target   = pc_rel;
        case (i_ctrl.next_pc)
            BRANCH_ZERO:    o_redirect = rc_zero;
            BRANCH_NONZERO: o_redirect = !rc_zero;
            TARGET_ALU: begin
                o_redirect = 1'b1;
                // jump already summed the pc in the alu
                if (i_ctrl.alu_src == SRC_PC) begin
                    o_target = alu_res[PC_W-1:0];
                end
            end
            TARGET_RB: begin
                o_redirect = 1'b1;
                o_target   = rf.rb_data[PC_W-1:0];
            end
            default: ;
        endcase
    end

    ////////////////////
    // write-back and memory
    assign rf.wen   = i_ctrl.rf_wen;
    assign rf.waddr = i_ra_addr;

    always_comb begin
        case (i_ctrl.wb_src)
            WB_MEM:  rf.wdata = dm.rdata;
            WB_LINK: rf.wdata = {{(XLEN-PC_W){1'b0}}, pc_inc};   // link is pc + 1
            default: rf.wdata = alu_res;
        endcase
    end

    assign dm.wen   = i_ctrl.mem_wen;
    assign dm.addr  = alu_res[PC_W-1:0];   // rb + offset, mod 256
    assign dm.wdata = rf.rc_data;

endmodule

`default_nettype wire

/* design/data_memory.sv */
////////////////////
// data memory, 256 x 32
////////////////////
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  wire logic i_clk,
    input  wire logic i_reset,
    dmem_if.mem       dm
);
    import isa_pkg::*;

    logic [XLEN-1:0] mem [DMEM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (dm.wen) begin
            mem[dm.addr] <= dm.wdata;
        end
    end

    assign dm.rdata = mem[dm.addr];   // async read

endmodule

`default_nettype wire

/* design/cpu_top.sv */
////////////////////
// single-cycle cpu top
// program load port and retirement trace
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire logic                       i_clk,
    input  wire logic                       i_reset,
    input  wire logic                       i_imem_we,
    input  wire logic [isa_pkg::PC_W-1:0]   i_imem_addr,
    input  wire logic [isa_pkg::XLEN-1:0]   i_imem_wdata,
    output logic      [isa_pkg::PC_W-1:0]   o_pc,
    output logic                            o_rf_wen,
    output logic      [isa_pkg::REG_AW-1:0] o_rf_waddr,
    output logic      [isa_pkg::XLEN-1:0]   o_rf_wdata,
    output logic                            o_mem_wen,
    output logic      [isa_pkg::PC_W-1:0]   o_mem_addr,
    output logic      [isa_pkg::XLEN-1:0]   o_mem_wdata
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [XLEN-1:0]   instr;
    logic              running;
    logic              redirect;
    logic [PC_W-1:0]   target;
    logic [REG_AW-1:0] ra_addr;
    ctrl_t             ctrl;

    regfile_if rf_bus ();
    dmem_if    dm_bus ();

    fetch_unit u_fetch (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .i_redirect   (redirect),
        .i_target     (target),
        .o_pc         (o_pc),
        .o_instr      (instr),
        .o_running    (running)
    );

    instr_decoder u_decode (
        .i_instr   (instr),
        .i_running (running),
        .rf        (rf_bus.core),
        .o_ctrl    (ctrl),
        .o_ra_addr (ra_addr)
    );

    register_file u_regs (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .rf      (rf_bus.regs)
    );

    execute_unit u_exec (
        .i_ctrl     (ctrl),
        .i_ra_addr  (ra_addr),
        .i_pc       (o_pc),
        .rf         (rf_bus.core),
        .dm         (dm_bus.core),
        .o_redirect (redirect),
        .o_target   (target)
    );

    data_memory u_dmem (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .dm      (dm_bus.mem)
    );

    // trace of the instruction that retires at the next edge
    assign o_rf_wen    = rf_bus.wen;
    assign o_rf_waddr  = rf_bus.waddr;
    assign o_rf_wdata  = rf_bus.wdata;
    assign o_mem_wen   = dm_bus.wen;
    assign o_mem_addr  = dm_bus.addr;
    assign o_mem_wdata = dm_bus.wdata;

endmodule

`default_nettype wire

/* test/tb_tests.svh */
////////////////////
// directed tests for cpu_top
// instruction encoder, program load and run, five test tasks
////////////////////
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic logic [31:0] enc(input logic [1:0] cls, input logic [2:0] opc,
                                    input logic [11:0] imm, input logic [4:0] rc,
                                    input logic [4:0] rb, input logic [4:0] ra);
    return {cls, opc, imm, rc, rb, ra};
endfunction

function automatic logic [31:0] loadi(input logic [4:0] ra, input logic [16:0] value);
    return enc(MOVEMENT, OP_LOADI, value[16:5], value[4:0], 5'd0, ra);
endfunction

task automatic put(input logic [31:0] instr);
    prog[prog_len] = instr;
    prog_len++;
endtask

// r31 stays 0, so jump r31 spins in place
task automatic put_halt();
    put(enc(FLOWCTRL, OP_JUMP, 12'd0, 5'd0, 5'd31, 5'd0));
endtask

// reset held while the program goes in, pc and strobes checked throughout
task automatic load_program();
    int n_cycles;
    n_cycles = (prog_len > 10) ? prog_len : 10;
    @(negedge clk);
    i_reset   = 1'b1;
    i_imem_we = 1'b0;
    @(posedge clk);
    for (int i = 0; i < n_cycles; i++) begin
        @(negedge clk);
        check_value("pc in reset", o_pc, 0);
        check_value("rf_wen in reset", o_rf_wen, 0);
        check_value("mem_wen in reset", o_mem_wen, 0);
        i_imem_we    = (i < prog_len);
        i_imem_addr  = i[7:0];
        i_imem_wdata = (i < prog_len) ? prog[i] : '0;
    end
    for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_DEPTH; i++) begin
        model_mem[i] = '0;
    end
    model_pc      = '0;
    model_running = 1'b0;
endtask

task automatic run_program();
    for (int i = 0; i < RUN_CYCLES; i++) begin
        @(negedge clk);
        if (i == 0) begin
            i_reset   = 1'b0;
            i_imem_we = 1'b0;
        end
        step_and_check();
    end
endtask

task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    prog_len = 0;
    for (int k = 0; k < 2; k++) begin
        a = lcg_next();
        b = lcg_next();
        put(loadi(5'd1, a[16:0]));
        put(loadi(5'd2, b[16:0]));
        put(enc(ARITHMETIC, OP_ADD, 12'd0, 5'd2, 5'd1, 5'd3));
        put(enc(ARITHMETIC, OP_SUB, 12'd0, 5'd2, 5'd3, 5'd4));
        put(enc(LOGIC, OP_OR, 12'd0, 5'd2, 5'd4, 5'd5));
        put(enc(LOGIC, OP_AND, 12'd0, 5'd2, 5'd1, 5'd6));
        put(enc(LOGIC, OP_INV, 12'd0, 5'd0, 5'd6, 5'd7));
    end
    put_halt();
    load_program();
    run_program();
endtask

task automatic test_mem();
    logic [31:0] base;
    logic [31:0] data;
    prog_len = 0;
    base = lcg_next();
    data = lcg_next();
    put(loadi(5'd1, {9'd0, base[7:0]}));
    put(loadi(5'd2, data[16:0]));
    put(enc(MOVEMENT, OP_STORE, 12'd5, 5'd2, 5'd1, 5'd0));      // mem[r1 + 5]
    put(enc(MOVEMENT, OP_LOAD, 12'd0, 5'd5, 5'd1, 5'd3));
    put(enc(MOVEMENT, OP_STORE, 12'hffd, 5'd3, 5'd1, 5'd0));    // negative offset
    put(enc(MOVEMENT, OP_LOAD, 12'hfff, 5'h1d, 5'd1, 5'd4));
    put(enc(MOVEMENT, OP_MOV, 12'd0, 5'd0, 5'd4, 5'd6));
    put_halt();
    load_program();
    run_program();
    check_value("loaded word", model_regs[6], {{15{data[16]}}, data[16:0]});
endtask

task automatic test_branch();
    prog_len = 0;
    put(loadi(5'd1, 17'd0));
    put(loadi(5'd2, 17'd7));
    put(loadi(5'd3, 17'd1));                                // rb offset for the branches
    put(enc(FLOWCTRL, OP_BZ, 12'd2, 5'd2, 5'd3, 5'd0));    // falls through
    put(enc(FLOWCTRL, OP_BZ, 12'd2, 5'd1, 5'd3, 5'd0));    // to 7
    put(loadi(5'd5, 17'h111));
    put(loadi(5'd5, 17'h222));
    put(enc(FLOWCTRL, OP_BNZ, 12'd1, 5'd1, 5'd3, 5'd0));   // falls through
    put(enc(FLOWCTRL, OP_BNZ, 12'd1, 5'd2, 5'd3, 5'd0));   // to 10
    put(loadi(5'd5, 17'h333));
    put(loadi(5'd4, 17'd3));
    put(enc(FLOWCTRL, OP_JUMP, 12'd0, 5'd0, 5'd4, 5'd0));  // 11 + 3
    put(loadi(5'd5, 17'h444));
    put(loadi(5'd5, 17'h555));
    put_halt();
    load_program();
    run_program();
    check_value("skipped writes", model_regs[5], 0);
endtask

task automatic test_jal_ret();
    logic [31:0] a;
    prog_len = 0;
    a = lcg_next();
    put(loadi(5'd6, a[16:0]));
    put(enc(FLOWCTRL, OP_JAL, 12'd0, 5'd4, 5'd0, 5'd10));  // to 5, link 2
    put(loadi(5'd7, 17'h55));
    put_halt();
    put(loadi(5'd8, 17'h88));
    put(loadi(5'd9, 17'h99));
    put(enc(FLOWCTRL, OP_RET, 12'd0, 5'd0, 5'd10, 5'd0));
    load_program();
    run_program();
    check_value("jal link", model_regs[10], 2);
endtask

task automatic test_reset_undef();
    prog_len = 0;
    put(loadi(5'd1, 17'd5));
    put(enc(ARITHMETIC, 3'b111, 12'd0, 5'd1, 5'd1, 5'd1));
    put(enc(MOVEMENT, 3'b011, 12'd0, 5'd1, 5'd1, 5'd1));
    put(enc(LOGIC, 3'b110, 12'd0, 5'd1, 5'd1, 5'd1));
    put(enc(FLOWCTRL, 3'b011, 12'd0, 5'd1, 5'd1, 5'd1));
    put_halt();
    load_program();
    run_program();
    load_program();   // reset again mid run
    run_program();
    check_value("reg after no-ops", model_regs[1], 5);
endtask

`endif

/* test/tb_cpu_top.sv */
////////////////////
// testbench for cpu_top
// clock, reset, DUT, reference model, trace checks, watchdog
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;
    import isa_pkg::*;

    localparam int MAX_PROG       = 20;
    localparam int RUN_CYCLES     = 24;   // per program, halt loop fills the tail
    localparam int NUM_RUNS       = 6;
    localparam int CYCLES_PER_RUN = 2 + MAX_PROG + RUN_CYCLES;
    localparam int WATCHDOG_NS    = 2 * NUM_RUNS * CYCLES_PER_RUN * 10;

    logic              clk;
    logic              i_reset;
    logic              i_imem_we;
    logic [PC_W-1:0]   i_imem_addr;
    logic [XLEN-1:0]   i_imem_wdata;
    logic [PC_W-1:0]   o_pc;
    logic              o_rf_wen;
    logic [REG_AW-1:0] o_rf_waddr;
    logic [XLEN-1:0]   o_rf_wdata;
    logic              o_mem_wen;
    logic [PC_W-1:0]   o_mem_addr;
    logic [XLEN-1:0]   o_mem_wdata;

    // reference model state
    logic [XLEN-1:0] prog [IMEM_DEPTH];
    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [XLEN-1:0] model_mem [DMEM_DEPTH];
    logic [PC_W-1:0] model_pc;
    logic            model_running;
    int              prog_len;
    int              error_count;
    logic [31:0]     rng_state;

    cpu_top DUT (
        .i_clk        (clk),
        .i_reset      (i_reset),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .o_pc         (o_pc),
        .o_rf_wen     (o_rf_wen),
        .o_rf_waddr   (o_rf_waddr),
        .o_rf_wdata   (o_rf_wdata),
        .o_mem_wen    (o_mem_wen),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, expected);
            $display("Done: errors found");
            $fatal(1, "stopping at first error");
        end
    endtask

    ////////////////////
    // reference model, one instruction per rising edge
    task automatic step_and_check();
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] rbv;
        logic [XLEN-1:0] rcv;
        logic [XLEN-1:0] imm_ext;
        logic [XLEN-1:0] imm_rc_ext;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] sum;
        logic [PC_W-1:0] maddr;
        logic [PC_W-1:0] npc;
        logic            rf_wen;
        logic            mem_wen;

        check_value("pc", o_pc, model_pc);
        if (!model_running) begin
            check_value("rf_wen before run", o_rf_wen, 0);
            check_value("mem_wen before run", o_mem_wen, 0);
            model_running = 1'b1;
            return;
        end
        instr      = prog[model_pc];
        rbv        = model_regs[instr[9:5]];
        rcv        = model_regs[instr[14:10]];
        imm_ext    = {{20{instr[26]}}, instr[26:15]};
        imm_rc_ext = {{15{instr[26]}}, instr[26:10]};
        rf_wen     = 1'b0;
        mem_wen    = 1'b0;
        wdata      = '0;
        maddr      = '0;
        npc        = model_pc + 8'd1;
        case (instr[31:30])
            MOVEMENT: begin
                case (instr[29:27])
                    OP_LOAD: begin
                        sum    = rbv + imm_rc_ext;
                        rf_wen = 1'b1;
                        wdata  = model_mem[sum[7:0]];
                    end
                    OP_STORE: begin
                        sum     = rbv + imm_ext;
                        mem_wen = 1'b1;
                        maddr   = sum[7:0];
                    end
                    OP_LOADI: begin
                        rf_wen = 1'b1;
                        wdata  = imm_rc_ext;
                    end
                    OP_MOV: begin
                        rf_wen = 1'b1;
                        wdata  = rbv;
                    end
                    default: ;
                endcase
            end
            LOGIC: begin
                rf_wen = (instr[29:27] == OP_OR) || (instr[29:27] == OP_AND)
                      || (instr[29:27] == OP_INV);
                wdata  = (instr[29:27] == OP_OR)  ? (rbv | rcv) :
                         (instr[29:27] == OP_AND) ? (rbv & rcv) : ~rbv;
            end
            ARITHMETIC: begin
                rf_wen = (instr[29:27] == OP_ADD) || (instr[29:27] == OP_SUB);
                wdata  = (instr[29:27] == OP_ADD) ? rbv + rcv : rbv - rcv;
            end
            default: begin
                case (instr[29:27])
                    OP_JUMP: npc = rbv[7:0] + model_pc;
                    OP_BZ:   npc = (rcv == 0) ? model_pc + rbv[7:0] + imm_ext[7:0] : npc;
                    OP_BNZ:  npc = (rcv != 0) ? model_pc + rbv[7:0] + imm_ext[7:0] : npc;
                    OP_JAL: begin
                        rf_wen = 1'b1;
                        wdata  = {24'd0, npc};          // link is pc + 1
                        npc    = model_pc + imm_rc_ext[7:0];
                    end
                    OP_RET:  npc = rbv[7:0];
                    default: ;
                endcase
            end
        endcase

        check_value("rf_wen", o_rf_wen, rf_wen);
        check_value("mem_wen", o_mem_wen, mem_wen);
        if (rf_wen) begin
            check_value("rf_waddr", o_rf_waddr, instr[4:0]);
            check_value("rf_wdata", o_rf_wdata, wdata);
            model_regs[instr[4:0]] = wdata;
        end
        if (mem_wen) begin
            check_value("mem_addr", o_mem_addr, maddr);
            check_value("mem_wdata", o_mem_wdata, rcv);
            model_mem[maddr] = rcv;
        end
        model_pc = npc;
    endtask

    `include "tb_tests.svh"

    initial begin
        i_reset      = 1'b1;
        i_imem_we    = 1'b0;
        i_imem_addr  = '0;
        i_imem_wdata = '0;
        error_count  = 0;
        rng_state    = 32'd45;
        prog_len     = 0;
        test_alu();
        test_mem();
        test_branch();
        test_jal_ret();
        test_reset_undef();
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog, twice the expected run length
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* cpu_top.f */
+incdir+test
design/isa_pkg.sv
design/core_pkg.sv
design/cpu_ifs.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/data_memory.sv
design/cpu_top.sv
test/tb_cpu_top.sv
